// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_float_add
RTL_TOP   ?= float_add_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
SIM_FLAGS ?= --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)
	$(VERILATOR) --lint-only verilog/float_fmt_pkg.sv verilog/fadd_ctrl_pkg.sv \
		verilog/fadd_ctrl.sv verilog/fadd_shift_counter.sv verilog/fadd_align.sv \
		verilog/fadd_mant_addsub.sv verilog/fadd_normalize.sv verilog/float_add_top.sv \
		--top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: flist.f
+incdir+testbench
verilog/float_fmt_pkg.sv
verilog/fadd_ctrl_pkg.sv
verilog/fadd_ctrl.sv
verilog/fadd_shift_counter.sv
verilog/fadd_align.sv
verilog/fadd_mant_addsub.sv
verilog/fadd_normalize.sv
verilog/float_add_top.sv
testbench/tb_float_add.sv

// File: testbench/tb_float_add_model.svh
`ifndef TB_FLOAT_ADD_MODEL_SVH
`define TB_FLOAT_ADD_MODEL_SVH

// hand-worked cases
// columns are operand a, operand b, expected sum
localparam int fixed_count = 8;
localparam logic [31:0] fixed_table [fixed_count][3] = '{
    '{32'h3FC00000, 32'h3FC00000, 32'h40400000},  // 1.5 + 1.5, mantissa carry
    '{32'h3F800000, 32'h40000000, 32'h40400000},  // 1 + 2, one step of alignment
    '{32'h3F800001, 32'hBF800000, 32'h34000000},  // near cancellation, 23 left shifts
    '{32'h3F800000, 32'h33000000, 32'h3F800000},  // b shifted out completely
    '{32'h3F800000, 32'h4C000000, 32'h4C000000},  // a shifted out completely
    '{32'h40490FDB, 32'hC0490FDB, 32'h00000000},  // equal magnitudes, opposite signs
    '{32'h3F800000, 32'hC0400000, 32'hC0000000},  // 1 - 3, sign from b
    '{32'hBFC00000, 32'hC0200000, 32'hC0800000}   // -1.5 + -2.5
};

// addition rules without rounding, shifts returns the number of left shifts
function automatic logic [31:0] fadd_model(input logic [31:0] x, input logic [31:0] y,
                                           output int shifts);
    logic [7:0]  xe;
    logic [7:0]  ye;
    logic [7:0]  e;
    logic [24:0] xm;
    logic [24:0] ym;
    logic [24:0] m;
    logic        s;
    xe = x[30:23];
    ye = y[30:23];
    // carry bit, hidden one, stored mantissa
    xm = {2'b01, x[22:0]};
    ym = {2'b01, y[22:0]};
    shifts = 0;
    if (xe > ye) begin
        e  = xe;
        ym = ym >> (xe - ye);
    end else begin
        e  = ye;
        xm = xm >> (ye - xe);
    end
    if (x[31] == y[31]) begin
        s = x[31];
        m = xm + ym;
    end else if (xm > ym) begin
        s = x[31];
        m = xm - ym;
    end else begin
        // a tie also lands here and takes y's sign
        s = y[31];
        m = ym - xm;
    end
    if (m[24]) begin
        m = m >> 1;
        e = e + 8'd1;
    end
    if (m == 25'd0) begin
        return 32'h0;
    end
    while (!m[23]) begin
        m = m << 1;
        e = e - 8'd1;
        shifts++;
    end
    return {s, e, m[22:0]};
endfunction

`endif

// File: testbench/tb_float_add.sv
`timescale 1ns/1ps

module tb_float_add;

    `include "tb_float_add_model.svh"

    localparam int random_count = 24;
    localparam int max_latency  = 40;
    // a second req is pulsed in the middle of this entry
    localparam int busy_entry   = 2;
    localparam int watchdog_cycles = (fixed_count + random_count) * max_latency + 100;

    logic                  clk;
    logic                  rst;
    logic                  req;
    float_fmt_pkg::float_t a;
    float_fmt_pkg::float_t b;
    float_fmt_pkg::float_t out;
    logic                  ack;

    integer seed = 12;
    int errors;
    int checks;
    int test_errors;
    int ack_pulses;

    // stimulus and expected values with the fixed cases first
    logic [31:0] op_a[$];
    logic [31:0] op_b[$];
    logic [31:0] want_sum[$];
    int          want_shifts[$];

    float_add_top dut_i (
        .clk (clk),
        .rst (rst),
        .req (req),
        .a   (a),
        .b   (b),
        .out (out),
        .ack (ack)
    );

    always #50 clk = ~clk;

    // every pulse out of reset is counted and compared with the requests at the end
    always @(negedge clk) begin
        if (!rst && ack) begin
            ack_pulses++;
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: the additions did not finish within %0d cycles", watchdog_cycles);
        $display("Something failed");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            test_errors++;
            $display("FAILED %s: got %08h, expected %08h", name, got, want);
        end
    endtask

    // free sign and mantissa with the exponent kept in 64..190 so nothing overflows
    function automatic logic [31:0] random_operand();
        logic [31:0] r;
        logic [7:0]  e;
        r = $random(seed);
        e = 8'(64 + ($unsigned($random(seed)) % 127));
        return {r[31], e, r[22:0]};
    endfunction

    task automatic run_entry(input int idx);
        int lat;
        test_errors = 0;
        @(negedge clk);
        a   = op_a[idx];
        b   = op_b[idx];
        req = 1'b1;
        @(negedge clk);
        req = 1'b0;
        lat = 0;
        while (!ack && lat < max_latency) begin
            @(negedge clk);
            lat++;
            // the unit is busy here so this req must not start anything
            req = (idx == busy_entry) && (lat == 1);
        end
        req = 1'b0;
        if (!ack) begin
            errors++;
            test_errors++;
            $display("test %0d: no ack within %0d cycles", idx, max_latency);
        end else begin
            check_value("out", out, want_sum[idx]);
            // 4 cycles of fixed phases plus one per left shift
            check_value("latency", 32'(lat), 32'(4 + want_shifts[idx]));
            @(negedge clk);
            check_value("ack", {31'b0, ack}, 32'h0);
        end
        if (test_errors == 0) begin
            $display("test %0d ok: %08h + %08h = %08h in %0d cycles",
                     idx, op_a[idx], op_b[idx], out, lat);
        end else begin
            $display("test %0d: %0d check(s) failed", idx, test_errors);
        end
    endtask

    initial begin
        logic [31:0] ra;
        logic [31:0] rb;
        int          shifts;
        clk = 1'b0;
        rst = 1'b1;
        req = 1'b0;
        a   = '0;
        b   = '0;
        errors = 0;
        checks = 0;
        ack_pulses = 0;
        for (int i = 0; i < fixed_count; i++) begin
            op_a.push_back(fixed_table[i][0]);
            op_b.push_back(fixed_table[i][1]);
            want_sum.push_back(fixed_table[i][2]);
            // model only supplies the shift count for hand-worked cases
            void'(fadd_model(fixed_table[i][0], fixed_table[i][1], shifts));
            want_shifts.push_back(shifts);
        end
        for (int i = 0; i < random_count; i++) begin
            ra = random_operand();
            rb = random_operand();
            op_a.push_back(ra);
            op_b.push_back(rb);
            want_sum.push_back(fadd_model(ra, rb, shifts));
            want_shifts.push_back(shifts);
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        test_errors = 0;
        check_value("ack", {31'b0, ack}, 32'h0);
        $display("reset: ack %s", (test_errors == 0) ? "low" : "wrong");
        for (int i = 0; i < op_a.size(); i++) begin
            run_entry(i);
        end
        repeat (5) @(negedge clk);
        // one pulse per request since the req while busy adds none
        check_value("ack pulses", 32'(ack_pulses), 32'(op_a.size()));
        $display("tests: %0d, checks: %0d, errors: %0d", op_a.size(), checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: verilog/fadd_align.sv
`timescale 1ns/1ps

module fadd_align (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  load_ops,
    input  float_fmt_pkg::float_t a,
    input  float_fmt_pkg::float_t b,
    output logic                  a_sign,
    output logic                  b_sign,
    output float_fmt_pkg::exp_t   big_exp,
    output float_fmt_pkg::wmant_t a_mant,
    output float_fmt_pkg::wmant_t b_mant
);

    float_fmt_pkg::exp_t   a_exp;
    float_fmt_pkg::exp_t   b_exp;
    float_fmt_pkg::exp_t   exp_diff;
    float_fmt_pkg::wmant_t a_full;
    float_fmt_pkg::wmant_t b_full;
    float_fmt_pkg::exp_t   big_exp_next;
    float_fmt_pkg::wmant_t a_mant_next;
    float_fmt_pkg::wmant_t b_mant_next;

    // field split
    assign a_exp = a[float_fmt_pkg::float_width - 2 -: float_fmt_pkg::exp_width];
    assign b_exp = b[float_fmt_pkg::float_width - 2 -: float_fmt_pkg::exp_width];

    // carry bit clear, hidden one set, stored mantissa below
    assign a_full = {2'b01, a[float_fmt_pkg::mant_width - 1:0]};
    assign b_full = {2'b01, b[float_fmt_pkg::mant_width - 1:0]};

    always_comb begin
        a_mant_next = a_full;
        b_mant_next = b_full;
        if (a_exp > b_exp) begin
            big_exp_next = a_exp;
            exp_diff     = a_exp - b_exp;
            // bits shifted out are dropped, no sticky bit
            b_mant_next  = b_full >> exp_diff;
        end else begin
            // equal exponents land here with a zero shift
            big_exp_next = b_exp;
            exp_diff     = b_exp - a_exp;
            a_mant_next  = a_full >> exp_diff;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            a_sign  <= 1'b0;
            b_sign  <= 1'b0;
            big_exp <= '0;
            a_mant  <= '0;
            b_mant  <= '0;
        end else if (load_ops) begin
            a_sign  <= a[float_fmt_pkg::float_width - 1];
            b_sign  <= b[float_fmt_pkg::float_width - 1];
            big_exp <= big_exp_next;
            a_mant  <= a_mant_next;
            b_mant  <= b_mant_next;
        end
    end

endmodule

// File: verilog/fadd_ctrl.sv
`timescale 1ns/1ps

module fadd_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic req,
    input  logic normalized,
    output logic load_ops,
    output logic load_sum,
    output logic load_norm,
    output logic shift_en,
    output logic pack,
    output logic ack
);

    fadd_ctrl_pkg::fadd_state_e state;
    fadd_ctrl_pkg::fadd_state_e state_next;

    // all datapath strobes side by side, for the protocol checks
    logic [4:0] strobes;

    // operands are taken on the same edge that sees req in idle
    assign load_ops  = (state == fadd_ctrl_pkg::IDLE) && req;
    // aligned mantissas are held during ALIGN, sum is taken at its end
    assign load_sum  = (state == fadd_ctrl_pkg::ALIGN);
    // sum is held during ADD, normalizer loads and counter clears
    assign load_norm = (state == fadd_ctrl_pkg::ADD);
    // one left shift per NORM cycle until the hidden bit shows up
    assign shift_en  = (state == fadd_ctrl_pkg::NORM) && !normalized;
    assign pack      = (state == fadd_ctrl_pkg::DONE);

    assign strobes = {load_ops, load_sum, load_norm, shift_en, pack};

    always_comb begin
        state_next = state;
        case (state)
            fadd_ctrl_pkg::IDLE: begin
                if (req) begin
                    state_next = fadd_ctrl_pkg::ALIGN;
                end
            end
            fadd_ctrl_pkg::ALIGN: begin
                state_next = fadd_ctrl_pkg::ADD;
            end
            fadd_ctrl_pkg::ADD: begin
                state_next = fadd_ctrl_pkg::NORM;
            end
            fadd_ctrl_pkg::NORM: begin
                // stay here while the mantissa still needs shifting
                if (normalized) begin
                    state_next = fadd_ctrl_pkg::DONE;
                end
            end
            fadd_ctrl_pkg::DONE: begin
                state_next = fadd_ctrl_pkg::IDLE;
            end
            default: begin
                state_next = fadd_ctrl_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= fadd_ctrl_pkg::IDLE;
            ack   <= 1'b0;
        end else begin
            state <= state_next;
            // registered together with out in the normalizer
            ack   <= (state == fadd_ctrl_pkg::DONE);
        end
    end

    // a result is announced for exactly one cycle
    ack_single_cycle: assert property (@(posedge clk) disable iff (rst)
        ack |=> !ack);

    // each busy phase drives its own strobe, NORM may sit idle for one cycle
    busy_strobe_onehot: assert property (@(posedge clk) disable iff (rst)
        (state != fadd_ctrl_pkg::IDLE) |->
            ((state == fadd_ctrl_pkg::NORM) ? $onehot0(strobes) : $onehot(strobes)));

    // no back-pressure, a request while busy is simply lost
    req_while_busy: assert property (@(posedge clk) disable iff (rst)
        req |-> (state == fadd_ctrl_pkg::IDLE))
        else $warning("fadd_ctrl: req ignored while busy");

endmodule

// File: verilog/fadd_ctrl_pkg.sv
package fadd_ctrl_pkg;

    // width of the normalization shift count
    localparam int shift_width = 5;

    typedef logic [shift_width - 1:0] shift_t;

    // hidden bit plus stored mantissa, so a nonzero value never needs more shifts
    localparam shift_t max_shift = shift_t'(24);

    // phases of one addition
    typedef enum logic [2:0] {
        IDLE,
        ALIGN,
        ADD,
        NORM,
        DONE
    } fadd_state_e;

endpackage

// File: verilog/fadd_mant_addsub.sv
`timescale 1ns/1ps

module fadd_mant_addsub (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  load_sum,
    input  logic                  a_sign,
    input  logic                  b_sign,
    input  float_fmt_pkg::exp_t   big_exp,
    input  float_fmt_pkg::wmant_t a_mant,
    input  float_fmt_pkg::wmant_t b_mant,
    output logic                  sum_sign,
    output float_fmt_pkg::exp_t   sum_exp,
    output float_fmt_pkg::wmant_t sum_mant
);

    logic                  sign_next;
    float_fmt_pkg::wmant_t mant_next;

    always_comb begin
        if (a_sign == b_sign) begin
            // same sign, magnitudes add and may carry into bit 24
            sign_next = a_sign;
            mant_next = a_mant + b_mant;
        end else if (a_mant > b_mant) begin
            // a is larger, result keeps a's sign
            sign_next = a_sign;
            mant_next = a_mant - b_mant;
        end else begin
            // b larger or a tie, tie gives a zero magnitude with b's sign
            sign_next = b_sign;
            mant_next = b_mant - a_mant;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sum_sign <= 1'b0;
            sum_exp  <= '0;
            sum_mant <= '0;
        end else if (load_sum) begin
            sum_sign <= sign_next;
            // exponent rides along unchanged
            sum_exp  <= big_exp;
            sum_mant <= mant_next;
        end
    end

endmodule

// File: verilog/fadd_normalize.sv
`timescale 1ns/1ps

module fadd_normalize (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  load_norm,
    input  logic                  shift_en,
    input  logic                  pack,
    input  logic                  sum_sign,
    input  float_fmt_pkg::exp_t   sum_exp,
    input  float_fmt_pkg::wmant_t sum_mant,
    input  fadd_ctrl_pkg::shift_t count,
    output logic                  normalized,
    output float_fmt_pkg::float_t out
);

    // working copy of the sum while it is being shifted
    logic                  sign_q;
    float_fmt_pkg::exp_t   exp_q;
    float_fmt_pkg::wmant_t mant_q;

    logic                  carry;
    logic                  mant_zero;
    float_fmt_pkg::exp_t   final_exp;

    assign carry     = sum_mant[float_fmt_pkg::mant_width + 1];
    assign mant_zero = (mant_q == '0);

    // hidden bit set or nothing left to find
    assign normalized = mant_q[float_fmt_pkg::mant_width] || mant_zero;

    // every left shift took one off the exponent
    assign final_exp = exp_q - float_fmt_pkg::exp_t'(count);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sign_q <= 1'b0;
            exp_q  <= '0;
            mant_q <= '0;
        end else if (load_norm) begin
            sign_q <= sum_sign;
            if (carry) begin
                // carry out moves right once and drops the lowest bit
                mant_q <= sum_mant >> 1;
                exp_q  <= sum_exp + float_fmt_pkg::exp_t'(1);
            end else begin
                mant_q <= sum_mant;
                exp_q  <= sum_exp;
            end
        end else if (shift_en) begin
            // one bit per cycle toward the hidden position
            mant_q <= mant_q << 1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out <= '0;
        end else if (pack) begin
            if (mant_zero) begin
                // exact cancellation gives positive zero
                out <= '0;
            end else begin
                out <= {sign_q, final_exp, mant_q[float_fmt_pkg::mant_width - 1:0]};
            end
        end
    end

endmodule

// File: verilog/fadd_shift_counter.sv
`timescale 1ns/1ps

module fadd_shift_counter (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  clear,
    input  logic                  step,
    output fadd_ctrl_pkg::shift_t count
);

    logic at_max;

    // holding at the limit keeps the exponent correction bounded
    assign at_max = (count == fadd_ctrl_pkg::max_shift);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (clear) begin
            // new addition starts from zero shifts
            count <= '0;
        end else if (step && !at_max) begin
            count <= count + fadd_ctrl_pkg::shift_t'(1);
        end
    end

    // a step at the limit means a zero mantissa was never flagged as
    // normalized and the controller kept on shifting
    no_step_at_max: assert property (@(posedge clk) disable iff (rst)
        step |-> !at_max);

    // clear and step come from different controller phases
    clear_step_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(clear && step));

endmodule

// File: verilog/float_add_top.sv
`timescale 1ns/1ps

module float_add_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req,
    input  float_fmt_pkg::float_t a,
    input  float_fmt_pkg::float_t b,
    output float_fmt_pkg::float_t out,
    output logic                  ack
);

    // controller strobes
    logic load_ops;
    logic load_sum;
    logic load_norm;
    logic shift_en;
    logic pack;
    // status back from the normalizer
    logic normalized;

    // aligned operands
    logic                  a_sign;
    logic                  b_sign;
    float_fmt_pkg::exp_t   big_exp;
    float_fmt_pkg::wmant_t a_mant;
    float_fmt_pkg::wmant_t b_mant;

    // raw sum before normalization
    logic                  sum_sign;
    float_fmt_pkg::exp_t   sum_exp;
    float_fmt_pkg::wmant_t sum_mant;

    fadd_ctrl_pkg::shift_t count;

    fadd_ctrl ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .normalized (normalized),
        .load_ops   (load_ops),
        .load_sum   (load_sum),
        .load_norm  (load_norm),
        .shift_en   (shift_en),
        .pack       (pack),
        .ack        (ack)
    );

    // cleared with the normalizer load, stepped with every shift
    fadd_shift_counter counter_i (
        .clk   (clk),
        .rst   (rst),
        .clear (load_norm),
        .step  (shift_en),
        .count (count)
    );

    fadd_align align_i (
        .clk      (clk),
        .rst      (rst),
        .load_ops (load_ops),
        .a        (a),
        .b        (b),
        .a_sign   (a_sign),
        .b_sign   (b_sign),
        .big_exp  (big_exp),
        .a_mant   (a_mant),
        .b_mant   (b_mant)
    );

    fadd_mant_addsub addsub_i (
        .clk      (clk),
        .rst      (rst),
        .load_sum (load_sum),
        .a_sign   (a_sign),
        .b_sign   (b_sign),
        .big_exp  (big_exp),
        .a_mant   (a_mant),
        .b_mant   (b_mant),
        .sum_sign (sum_sign),
        .sum_exp  (sum_exp),
        .sum_mant (sum_mant)
    );

    fadd_normalize normalize_i (
        .clk        (clk),
        .rst        (rst),
        .load_norm  (load_norm),
        .shift_en   (shift_en),
        .pack       (pack),
        .sum_sign   (sum_sign),
        .sum_exp    (sum_exp),
        .sum_mant   (sum_mant),
        .count      (count),
        .normalized (normalized),
        .out        (out)
    );

endmodule

// File: verilog/float_fmt_pkg.sv
package float_fmt_pkg;

    // single precision word layout
    localparam int float_width = 32;
    localparam int exp_width   = 8;
    localparam int mant_width  = 23;

    // whole word, sign in the top bit, then exponent, then stored mantissa
    typedef logic [float_width - 1:0] float_t;

    // exponent field, handled as a plain unsigned number
    typedef logic [exp_width - 1:0] exp_t;

    // working mantissa used through the datapath
    // bit 24 catches the carry of an addition
    // bit 23 holds the hidden one
    // bits 22:0 are the stored mantissa
    typedef logic [mant_width + 1:0] wmant_t;

endpackage
